// ==== tb.f ====
logic/rv_pkg.sv
logic/regfile.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/rv_core.sv
sim/rv_core_checker.sv
sim/rv_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/rv_core_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== sim/rv_core_tb.sv ====
//****************************************
// loads a program into rv_core during reset
// and checks every retire against a table
//****************************************
`timescale 1ns/10ps

module rv_core_tb import rv_pkg::*; ();

  localparam int    COMMIT_TIMEOUT = 50;
  localparam int    RESET_CYCLES   = 10;
  localparam xlen_t LOOP_PC        = 64'h50;

  typedef struct packed {
    logic [2:0] group;
    xlen_t      pc;
    logic       wen;
    reg_addr_t  rd;
    xlen_t      data;
  } retire_t;

  logic        clock;
  logic        reset;
  logic        imem_we;
  xlen_t       imem_addr;
  logic [31:0] imem_data;
  commit_t     commit;

  logic [31:0] prog_q [$];
  retire_t     exp_q [$];
  int          group_errors = 0;
  int          total_errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          commits      = 0;
  logic        loop_seen    = 1'b0;
  logic        timed_out    = 1'b0;

  rv_core #(
    .PC_START   (64'h0),
    .IMEM_DEPTH (64),
    .DMEM_DEPTH (64)
  ) u_dut (
    .clock     (clock),
    .reset     (reset),
    .imem_we   (imem_we),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .commit    (commit)
  );

  initial clock = 1'b0;
  always #5 clock = ~clock;

  // every retire ahead of the first self-loop commit, reset included
  always @(negedge clock) begin
    if (commit.valid && !loop_seen) begin
      if (commit.pc == LOOP_PC) begin
        loop_seen <= 1'b1;
      end else begin
        commits <= commits + 1;
      end
    end
  end

  function automatic logic [31:0] r_type(input logic [6:0] funct7, input reg_addr_t rs2,
                                         input reg_addr_t rs1, input logic [2:0] funct3,
                                         input reg_addr_t rd);
    return {funct7, rs2, rs1, funct3, rd, op_reg};
  endfunction

  function automatic logic [31:0] i_type(input int imm, input reg_addr_t rs1,
                                         input logic [2:0] funct3, input reg_addr_t rd,
                                         input opcode_t opcode);
    return {imm[11:0], rs1, funct3, rd, opcode};
  endfunction

  // sd only with funct3 fixed
  function automatic logic [31:0] s_type(input int imm, input reg_addr_t rs2,
                                         input reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] b_type(input int offset, input reg_addr_t rs2,
                                         input reg_addr_t rs1, input logic [2:0] funct3);
    return {offset[12], offset[10:5], rs2, rs1, funct3, offset[4:1], offset[11], op_branch};
  endfunction

  function automatic string group_title(input logic [2:0] group);
    case (group)
      3'd1:    return "back-to-back forwarding";
      3'd2:    return "store then load";
      3'd3:    return "load-use stall";
      3'd4:    return "taken branch";
      3'd5:    return "bne fall-through and x0";
      default: return "commit count";
    endcase
  endfunction

  task automatic append_word(input logic [31:0] word);
    prog_q.push_back(word);
  endtask

  task automatic expect_retire(input logic [2:0] group, input xlen_t pc, input logic wen,
                               input reg_addr_t rd, input xlen_t data);
    retire_t e;
    e.group = group;
    e.pc    = pc;
    e.wen   = wen;
    e.rd    = rd;
    e.data  = data;
    exp_q.push_back(e);
  endtask

  task automatic build_tables();
    // forwarding chain
    append_word(i_type(5, 5'd0, 3'b000, 5'd1, op_imm));
    append_word(r_type(7'h00, 5'd1, 5'd1, 3'b000, 5'd2));
    append_word(r_type(7'h20, 5'd1, 5'd2, 3'b000, 5'd3));
    append_word(r_type(7'h00, 5'd2, 5'd3, 3'b100, 5'd4));
    append_word(r_type(7'h00, 5'd2, 5'd4, 3'b111, 5'd5));
    // sd then ld at address 16
    append_word(i_type(-3, 5'd0, 3'b000, 5'd6, op_imm));
    append_word(s_type(6, 5'd6, 5'd2));
    append_word(i_type(6, 5'd2, 3'b011, 5'd7, op_load));
    // x10 used right after its load
    append_word(i_type(100, 5'd0, 3'b000, 5'd9, op_imm));
    append_word(s_type(24, 5'd9, 5'd0));
    append_word(i_type(24, 5'd0, 3'b011, 5'd10, op_load));
    append_word(r_type(7'h00, 5'd1, 5'd10, 3'b000, 5'd11));
    append_word(r_type(7'h20, 5'd10, 5'd11, 3'b000, 5'd12));
    // beq x1, x3 jumps over two writes of x13
    append_word(b_type(12, 5'd3, 5'd1, 3'b000));
    append_word(i_type(1, 5'd0, 3'b000, 5'd13, op_imm));
    append_word(i_type(2, 5'd0, 3'b000, 5'd13, op_imm));
    append_word(i_type(7, 5'd1, 3'b000, 5'd14, op_imm));
    append_word(b_type(8, 5'd2, 5'd2, 3'b001));
    append_word(i_type(9, 5'd1, 3'b000, 5'd0, op_imm));
    append_word(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd15));
    // closing self-loop followed by words that must never retire
    append_word(b_type(0, 5'd0, 5'd0, 3'b000));
    append_word(i_type(3, 5'd0, 3'b000, 5'd13, op_imm));
    append_word(i_type(4, 5'd0, 3'b000, 5'd13, op_imm));

    expect_retire(3'd1, 64'h00, 1'b1, 5'd1, 64'd5);
    expect_retire(3'd1, 64'h04, 1'b1, 5'd2, 64'd10);
    expect_retire(3'd1, 64'h08, 1'b1, 5'd3, 64'd5);
    expect_retire(3'd1, 64'h0c, 1'b1, 5'd4, 64'd15);
    expect_retire(3'd1, 64'h10, 1'b1, 5'd5, 64'd10);
    expect_retire(3'd2, 64'h14, 1'b1, 5'd6, 64'hffff_ffff_ffff_fffd);
    expect_retire(3'd2, 64'h18, 1'b0, 5'd0, 64'd0);
    expect_retire(3'd2, 64'h1c, 1'b1, 5'd7, 64'hffff_ffff_ffff_fffd);
    expect_retire(3'd3, 64'h20, 1'b1, 5'd9, 64'd100);
    expect_retire(3'd3, 64'h24, 1'b0, 5'd0, 64'd0);
    expect_retire(3'd3, 64'h28, 1'b1, 5'd10, 64'd100);
    expect_retire(3'd3, 64'h2c, 1'b1, 5'd11, 64'd105);
    expect_retire(3'd3, 64'h30, 1'b1, 5'd12, 64'd5);
    expect_retire(3'd4, 64'h34, 1'b0, 5'd0, 64'd0);
    expect_retire(3'd4, 64'h40, 1'b1, 5'd14, 64'd12);
    expect_retire(3'd5, 64'h44, 1'b0, 5'd0, 64'd0);
    expect_retire(3'd5, 64'h48, 1'b0, 5'd0, 64'd0);
    expect_retire(3'd5, 64'h4c, 1'b1, 5'd15, 64'd5);
  endtask

  task automatic await_commit(output logic found);
    int cycles;
    found  = 1'b0;
    cycles = 0;
    while (!found && cycles < COMMIT_TIMEOUT) begin
      @(negedge clock);
      cycles++;
      if (commit.valid) begin
        found = 1'b1;
      end
    end
  endtask

  task automatic compare_commit(input retire_t e, input int idx);
    assert (commit.pc == e.pc) else begin
      $display("ERROR @%0t: entry %0d pc %h, expected %h", $time, idx, commit.pc, e.pc);
      group_errors++;
    end
    assert (commit.wen == e.wen) else begin
      $display("ERROR @%0t: entry %0d wen %b, expected %b", $time, idx, commit.wen, e.wen);
      group_errors++;
    end
    // rd and data only mean something on a register write
    if (e.wen) begin
      assert (commit.rd == e.rd) else begin
        $display("ERROR @%0t: entry %0d rd x%0d, expected x%0d", $time, idx, commit.rd, e.rd);
        group_errors++;
      end
      assert (commit.data == e.data) else begin
        $display("ERROR @%0t: entry %0d data %h, expected %h",
                 $time, idx, commit.data, e.data);
        group_errors++;
      end
    end
  endtask

  task automatic report_group(input logic [2:0] group);
    if (group_errors == 0) begin
      $display("test %0d %s: pass", group, group_title(group));
      tests_passed++;
    end else begin
      $display("test %0d %s: fail with %0d errors", group, group_title(group), group_errors);
      tests_failed++;
    end
    total_errors += group_errors;
    group_errors = 0;
  endtask

  initial begin
    logic    found;
    retire_t e;
    reset     = 1'b1;
    imem_we   = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    build_tables();

    // reset stays high through the load and ten more cycles
    for (int i = 0; i < prog_q.size(); i++) begin
      @(posedge clock);
      imem_we   <= 1'b1;
      imem_addr <= xlen_t'(i * 4);
      imem_data <= prog_q[i];
    end
    @(posedge clock);
    imem_we <= 1'b0;
    repeat (RESET_CYCLES - 1) @(posedge clock);
    reset <= 1'b0;

    for (int i = 0; i < exp_q.size(); i++) begin
      e = exp_q[i];
      await_commit(found);
      if (!found) begin
        $display("timeout: no commit within %0d cycles for table entry %0d",
                 COMMIT_TIMEOUT, i);
        timed_out = 1'b1;
        group_errors++;
        report_group(e.group);
        break;
      end
      compare_commit(e, i);
      if (i == exp_q.size() - 1) begin
        report_group(e.group);
      end else if (exp_q[i + 1].group != e.group) begin
        report_group(e.group);
      end
    end

    // the next retire after the table must be the self-loop
    if (!timed_out) begin
      await_commit(found);
      if (!found) begin
        $display("timeout: the closing loop branch never committed");
        timed_out = 1'b1;
        group_errors++;
      end else begin
        assert (commit.pc == LOOP_PC) else begin
          $display("ERROR @%0t: commit after table has pc %h, expected loop pc %h",
                   $time, commit.pc, LOOP_PC);
          group_errors++;
        end
      end
      assert (commits == exp_q.size()) else begin
        $display("ERROR @%0t: %0d commits before the loop, expected %0d",
                 $time, commits, exp_q.size());
        group_errors++;
      end
      report_group(3'd6);
    end

    $display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
    if (!timed_out && total_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/rv_core_checker.sv ====
//****************************************
// commit and redirect assertions, bound into rv_core
//****************************************
`timescale 1ns/10ps

module rv_core_checker import rv_pkg::*; (
  input logic    clock,
  input logic    reset,
  input commit_t commit,
  input logic    redirect,
  input xlen_t   redirect_pc,
  input xlen_t   fetch_pc
);

  // x0 is never reported as written
  wen_needs_rd: assert property (
    @(posedge clock) disable iff (reset) commit.wen |-> (commit.rd != '0)
  ) else $error("commit wen high with rd x0 at pc %h", commit.pc);

  quiet_in_reset: assert property (
    @(posedge clock) reset |=> !commit.valid
  ) else $error("commit valid while reset is high");

  // taken branch lands on its target one edge later
  redirect_lands: assert property (
    @(posedge clock) disable iff (reset) redirect |=> (fetch_pc == $past(redirect_pc))
  ) else $error("fetch pc %h does not match redirect target", fetch_pc);

endmodule

bind rv_core rv_core_checker u_checker (
  .clock       (clock),
  .reset       (reset),
  .commit      (commit),
  .redirect    (redirect),
  .redirect_pc (redirect_pc),
  .fetch_pc    (u_fetch.pc)
);

// ==== logic/rv_core.sv ====
//****************************************
// rv64 five-stage core top level
// load imem during reset, watch commit
//****************************************
`timescale 1ns/10ps

module rv_core import rv_pkg::*; #(
  parameter xlen_t PC_START   = 64'h0,
  parameter int    IMEM_DEPTH = 64,
  parameter int    DMEM_DEPTH = 64
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        imem_we,
  input  xlen_t       imem_addr,
  input  logic [31:0] imem_data,
  output commit_t     commit
);

  inst_u   if_inst;
  xlen_t   if_pc;
  logic    if_valid;
  logic    stall;
  logic    redirect;
  xlen_t   redirect_pc;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  mem_wb_t wb;

  fetch_stage #(
    .PC_START   (PC_START),
    .IMEM_DEPTH (IMEM_DEPTH)
  ) u_fetch (
    .clock       (clock),
    .reset       (reset),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .imem_we     (imem_we),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .if_inst     (if_inst),
    .if_pc       (if_pc),
    .if_valid    (if_valid)
  );

  decode_stage u_decode (
    .clock    (clock),
    .reset    (reset),
    .if_inst  (if_inst),
    .if_pc    (if_pc),
    .if_valid (if_valid),
    .redirect (redirect),
    .wb       (wb),
    .stall    (stall),
    .id_ex    (id_ex)
  );

  execute_stage u_execute (
    .clock       (clock),
    .reset       (reset),
    .id_ex       (id_ex),
    .wb          (wb),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .ex_mem      (ex_mem)
  );

  memory_stage #(
    .DMEM_DEPTH (DMEM_DEPTH)
  ) u_memory (
    .clock  (clock),
    .reset  (reset),
    .ex_mem (ex_mem),
    .wb     (wb),
    .commit (commit)
  );

endmodule

// ==== logic/memory_stage.sv ====
//****************************************
// memory: data ram, mem/wb register and
// the commit report from writeback
//****************************************
`timescale 1ns/10ps

module memory_stage import rv_pkg::*; #(
  parameter int DMEM_DEPTH = 64
) (
  input  logic    clock,
  input  logic    reset,
  input  ex_mem_t ex_mem,
  output mem_wb_t wb,
  output commit_t commit
);

  localparam int DMEM_AW = $clog2(DMEM_DEPTH);

  xlen_t              dmem [DMEM_DEPTH];
  logic [DMEM_AW-1:0] dmem_idx;
  xlen_t              load_data;

  // doubleword addressing, low three bits dropped
  assign dmem_idx  = ex_mem.result[DMEM_AW+2:3];
  assign load_data = dmem[dmem_idx];

  always_ff @(posedge clock) begin
    if (ex_mem.valid && ex_mem.is_store) begin
      dmem[dmem_idx] <= ex_mem.store_data;
    end
  end

  always_ff @(posedge clock) begin
    wb.pc        <= ex_mem.pc;
    wb.data      <= ex_mem.is_load ? load_data : ex_mem.result;
    wb.rd        <= ex_mem.rd;
    wb.reg_write <= ex_mem.reg_write;
    if (reset) begin
      wb.valid <= 1'b0;
    end else begin
      wb.valid <= ex_mem.valid;
    end
  end

  // retire report, one cycle behind writeback
  always_ff @(posedge clock) begin
    commit.pc   <= wb.pc;
    commit.rd   <= wb.rd;
    commit.data <= wb.data;
    if (reset) begin
      commit.valid <= 1'b0;
      commit.wen   <= 1'b0;
    end else begin
      commit.valid <= wb.valid;
      commit.wen   <= wb.valid && wb.reg_write && (wb.rd != '0);
    end
  end

endmodule

// ==== logic/execute_stage.sv ====
//****************************************
// execute: forwarding, alu, branch compare
// and the ex/mem register
//****************************************
`timescale 1ns/10ps

module execute_stage import rv_pkg::*; (
  input  logic    clock,
  input  logic    reset,
  input  id_ex_t  id_ex,
  input  mem_wb_t wb,
  output logic    redirect,
  output xlen_t   redirect_pc,
  output ex_mem_t ex_mem
);

  xlen_t op_a;
  xlen_t rs2_val;
  xlen_t alu_b;
  xlen_t alu_res;
  logic  operands_eq;

  // memory stage first, then writeback, then the decode-time read
  function automatic xlen_t fwd(
    input reg_addr_t rs,
    input xlen_t     rf_data,
    input ex_mem_t   mem_src,
    input mem_wb_t   wb_src
  );
    xlen_t val;
    val = rf_data;
    if (rs != '0) begin
      if (mem_src.valid && mem_src.reg_write && mem_src.rd == rs) begin
        val = mem_src.result;
      end else if (wb_src.valid && wb_src.reg_write && wb_src.rd == rs) begin
        val = wb_src.data;
      end
    end
    return val;
  endfunction

  assign op_a    = fwd(id_ex.rs1, id_ex.rs1_data, ex_mem, wb);
  assign rs2_val = fwd(id_ex.rs2, id_ex.rs2_data, ex_mem, wb);
  assign alu_b   = id_ex.use_imm ? id_ex.imm : rs2_val;

  always_comb begin
    case (id_ex.alu_op)
      alu_sub: alu_res = op_a - alu_b;
      alu_and: alu_res = op_a & alu_b;
      alu_or:  alu_res = op_a | alu_b;
      alu_xor: alu_res = op_a ^ alu_b;
      default: alu_res = op_a + alu_b;
    endcase
  end

  // beq takes on equal, bne on not equal
  assign operands_eq = (op_a == rs2_val);
  assign redirect    = id_ex.valid && id_ex.is_branch &&
                       (operands_eq != id_ex.branch_ne);
  assign redirect_pc = id_ex.pc + id_ex.imm;

  always_ff @(posedge clock) begin
    ex_mem.pc         <= id_ex.pc;
    ex_mem.result     <= alu_res;
    ex_mem.store_data <= rs2_val;
    ex_mem.is_load    <= id_ex.is_load;
    ex_mem.is_store   <= id_ex.is_store;
    ex_mem.rd         <= id_ex.rd;
    ex_mem.reg_write  <= id_ex.reg_write;
    if (reset) begin
      ex_mem.valid <= 1'b0;
    end else begin
      ex_mem.valid <= id_ex.valid;
    end
  end

endmodule

// ==== logic/decode_stage.sv ====
//****************************************
// decode: field decode, register reads,
// load-use stall and the id/ex register
//****************************************
`timescale 1ns/10ps

module decode_stage import rv_pkg::*; (
  input  logic    clock,
  input  logic    reset,
  input  inst_u   if_inst,
  input  xlen_t   if_pc,
  input  logic    if_valid,
  input  logic    redirect,
  input  mem_wb_t wb,
  output logic    stall,
  output id_ex_t  id_ex
);

  inst_u   dec;
  xlen_t   imm;
  alu_op_t alu_op;
  logic    use_imm;
  logic    is_load;
  logic    is_store;
  logic    is_branch;
  logic    reg_write;
  logic    use_rs1;
  logic    use_rs2;
  xlen_t   rdata1;
  xlen_t   rdata2;

  // flushed or empty slot decodes as a nop
  assign dec = (if_valid && !redirect) ? if_inst : nop_inst;

  always_comb begin
    imm       = '0;
    alu_op    = alu_add;
    use_imm   = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    reg_write = 1'b0;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    case (dec.r_fmt.opcode)
      op_reg: begin
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        reg_write = (dec.r_fmt.funct7 == 7'h00) ||
                    (dec.r_fmt.funct7 == 7'h20 && dec.r_fmt.funct3 == 3'b000);
        case (dec.r_fmt.funct3)
          3'b000:  alu_op = dec.r_fmt.funct7[5] ? alu_sub : alu_add;
          3'b100:  alu_op = alu_xor;
          3'b110:  alu_op = alu_or;
          3'b111:  alu_op = alu_and;
          default: reg_write = 1'b0;
        endcase
      end
      op_imm: begin
        use_rs1   = 1'b1;
        use_imm   = 1'b1;
        imm       = {{52{dec.i_fmt.imm[11]}}, dec.i_fmt.imm};
        reg_write = (dec.i_fmt.funct3 == 3'b000);
      end
      op_load: begin
        use_rs1   = 1'b1;
        use_imm   = 1'b1;
        imm       = {{52{dec.i_fmt.imm[11]}}, dec.i_fmt.imm};
        is_load   = (dec.i_fmt.funct3 == 3'b011);
        reg_write = (dec.i_fmt.funct3 == 3'b011);
      end
      op_store: begin
        use_rs1  = 1'b1;
        use_rs2  = 1'b1;
        use_imm  = 1'b1;
        imm      = {{52{dec.s_fmt.imm_hi[6]}}, dec.s_fmt.imm_hi, dec.s_fmt.imm_lo};
        is_store = (dec.s_fmt.funct3 == 3'b011);
      end
      op_branch: begin
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        imm       = {{51{dec.b_fmt.imm12}}, dec.b_fmt.imm12, dec.b_fmt.imm11,
                     dec.b_fmt.imm10_5, dec.b_fmt.imm4_1, 1'b0};
        is_branch = (dec.b_fmt.funct3[2:1] == 2'b00);
      end
      default: ;
    endcase
  end

  // load in execute feeding this instruction
  assign stall = id_ex.valid && id_ex.is_load && (id_ex.rd != '0) &&
                 ((use_rs1 && dec.r_fmt.rs1 == id_ex.rd) ||
                  (use_rs2 && dec.r_fmt.rs2 == id_ex.rd));

  regfile u_regfile (
    .clock  (clock),
    .rs1    (dec.r_fmt.rs1),
    .rs2    (dec.r_fmt.rs2),
    .rd     (wb.rd),
    .wen    (wb.valid && wb.reg_write && (wb.rd != '0)),
    .wdata  (wb.data),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  always_ff @(posedge clock) begin
    id_ex.pc        <= if_pc;
    id_ex.rs1       <= dec.r_fmt.rs1;
    id_ex.rs2       <= dec.r_fmt.rs2;
    id_ex.rs1_data  <= rdata1;
    id_ex.rs2_data  <= rdata2;
    id_ex.imm       <= imm;
    id_ex.alu_op    <= alu_op;
    id_ex.use_imm   <= use_imm;
    id_ex.is_load   <= is_load;
    id_ex.is_store  <= is_store;
    id_ex.is_branch <= is_branch;
    id_ex.branch_ne <= dec.b_fmt.funct3[0];
    id_ex.rd        <= dec.r_fmt.rd;
    id_ex.reg_write <= reg_write;
    // bubble on stall or flush
    if (reset) begin
      id_ex.valid <= 1'b0;
    end else begin
      id_ex.valid <= if_valid && !stall && !redirect;
    end
  end

endmodule

// ==== logic/fetch_stage.sv ====
//****************************************
// fetch: pc, instruction memory and the
// fetch-to-decode register
//****************************************
`timescale 1ns/10ps

module fetch_stage import rv_pkg::*; #(
  parameter xlen_t PC_START   = 64'h0,
  parameter int    IMEM_DEPTH = 64
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        stall,
  input  logic        redirect,
  input  xlen_t       redirect_pc,
  input  logic        imem_we,
  input  xlen_t       imem_addr,
  input  logic [31:0] imem_data,
  output inst_u       if_inst,
  output xlen_t       if_pc,
  output logic        if_valid
);

  localparam int IMEM_AW = $clog2(IMEM_DEPTH);

  logic [31:0]        imem [IMEM_DEPTH];
  xlen_t              pc;
  logic [IMEM_AW-1:0] fetch_idx;
  logic [IMEM_AW-1:0] load_idx;

  // both ports take byte addresses
  assign fetch_idx = pc[IMEM_AW+1:2];
  assign load_idx  = imem_addr[IMEM_AW+1:2];

  always_ff @(posedge clock) begin
    if (imem_we) begin
      imem[load_idx] <= imem_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= PC_START;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (!stall) begin
      pc <= pc + 64'd4;
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      if_inst <= imem[fetch_idx];
      if_pc   <= pc;
    end
    // younger fetch dies on a taken branch
    if (reset || redirect) begin
      if_valid <= 1'b0;
    end else if (!stall) begin
      if_valid <= 1'b1;
    end
  end

endmodule

// ==== logic/regfile.sv ====
//****************************************
// integer register file, 2 reads 1 write
//****************************************
`timescale 1ns/10ps

module regfile import rv_pkg::*; (
  input  logic      clock,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  reg_addr_t rd,
  input  logic      wen,
  input  xlen_t     wdata,
  output xlen_t     rdata1,
  output xlen_t     rdata2
);

  xlen_t regs [32];

  always_ff @(posedge clock) begin
    if (wen) begin
      regs[rd] <= wdata;
    end
  end

  // x0 is hardwired, same-cycle write is bypassed
  assign rdata1 = (rs1 == '0) ? '0 :
                  (wen && rd == rs1) ? wdata : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 :
                  (wen && rd == rs2) ? wdata : regs[rs2];

endmodule

// ==== logic/rv_pkg.sv ====
//****************************************
// shared types for the rv64 pipeline core
// imported by every stage and the testbench
//****************************************
package rv_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [4:0]  reg_addr_t;

  typedef enum logic [6:0] {
    op_load   = 7'b0000011,
    op_imm    = 7'b0010011,
    op_store  = 7'b0100011,
    op_reg    = 7'b0110011,
    op_branch = 7'b1100011
  } opcode_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor
  } alu_op_t;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    opcode_t    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    opcode_t     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_t    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    opcode_t    opcode;
  } b_fmt_t;

  // one instruction word, four field layouts
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
  } inst_u;

  typedef struct packed {
    logic      valid;
    xlen_t     pc;
    reg_addr_t rs1;
    reg_addr_t rs2;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    xlen_t     imm;
    alu_op_t   alu_op;
    logic      use_imm;
    logic      is_load;
    logic      is_store;
    logic      is_branch;
    logic      branch_ne;
    reg_addr_t rd;
    logic      reg_write;
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    xlen_t     pc;
    xlen_t     result;
    xlen_t     store_data;
    logic      is_load;
    logic      is_store;
    reg_addr_t rd;
    logic      reg_write;
  } ex_mem_t;

  typedef struct packed {
    logic      valid;
    xlen_t     pc;
    xlen_t     data;
    reg_addr_t rd;
    logic      reg_write;
  } mem_wb_t;

  typedef struct packed {
    logic      valid;
    xlen_t     pc;
    reg_addr_t rd;
    logic      wen;
    xlen_t     data;
  } commit_t;

  // addi x0, x0, 0
  localparam inst_u nop_inst = 32'h0000_0013;

endpackage
